/* all.f */
+incdir+tb
rtl/decode_pkg.sv
rtl/inst_matcher.sv
rtl/ctrl_gen.sv
rtl/imm_gen.sv
rtl/reg_file.sv
rtl/decode_stage.sv
tb/decode_stage_tb.sv

/* rtl/ctrl_gen.sv */
module ctrl_gen
    import decode_pkg::*;
(
    input  inst_kind_t kind,
    input  reg_idx_t   rd_field,
    output ctrl_t      ctrl,
    output imm_kind_t  imm_kind
);

    exec_unit_t unit;
    alu_op_t    alu_op;
    mul_op_t    mul_op;
    div_op_t    div_op;
    logic [3:0] exec_op;
    src1_sel_t  src1;
    cmp_cond_t  cmp;
    logic       is_branch;
    mem_len_t   len;
    mem_rw_t    rw;
    wb_src_t    wb_src;

    always_comb begin
        case (kind)
            INST_ADD_W, INST_SUB_W, INST_ADDI_W, INST_LU12I_W, INST_PCADDU12I,
            INST_AND, INST_OR, INST_NOR, INST_XOR, INST_ANDI, INST_ORI, INST_XORI,
            INST_SLL_W, INST_SRL_W, INST_SRA_W, INST_SLLI_W, INST_SRLI_W, INST_SRAI_W,
            INST_BEQ, INST_BNE, INST_BLT, INST_BGE, INST_BLTU, INST_BGEU,
            INST_B, INST_BL, INST_JIRL,
            INST_LD_B, INST_LD_H, INST_LD_W, INST_LD_BU, INST_LD_HU,
            INST_ST_B, INST_ST_H, INST_ST_W:                  unit = EXU_ALU;
            INST_MUL_W, INST_MULH_W, INST_MULH_WU:             unit = EXU_MUL;
            INST_DIV_W, INST_DIV_WU, INST_MOD_W, INST_MOD_WU:  unit = EXU_DIV;
            INST_SLT, INST_SLTU, INST_SLTI, INST_SLTUI:        unit = EXU_CMP;
            default:                                           unit = EXU_NONE;
        endcase
    end

    // address and target adds fall through to ADD
    always_comb begin
        case (kind)
            INST_SUB_W:                           alu_op = SUB;
            INST_AND, INST_ANDI:                  alu_op = AND;
            INST_OR, INST_ORI:                    alu_op = OR;
            INST_NOR:                             alu_op = NOR;
            INST_XOR, INST_XORI:                  alu_op = XOR;
            INST_SLL_W, INST_SLLI_W:              alu_op = SLL;
            INST_SRL_W, INST_SRLI_W:              alu_op = SRL;
            INST_SRA_W, INST_SRAI_W:              alu_op = SRA;
            default:                              alu_op = ADD;
        endcase
    end

    always_comb begin
        case (kind)
            INST_MULH_W:  mul_op = MUL_HI;
            INST_MULH_WU: mul_op = MUL_HIU;
            default:      mul_op = MUL_LO;
        endcase
        case (kind)
            INST_DIV_WU: div_op = DIV_QU;
            INST_MOD_W:  div_op = DIV_R;
            INST_MOD_WU: div_op = DIV_RU;
            default:     div_op = DIV_Q;
        endcase
    end

    always_comb begin
        case (unit)
            EXU_ALU: exec_op = alu_op;
            EXU_MUL: exec_op = mul_op;
            EXU_DIV: exec_op = div_op;
            default: exec_op = '0;
        endcase
    end

    always_comb begin
        case (kind)
            INST_SLLI_W, INST_SRLI_W, INST_SRAI_W:           imm_kind = IMM_UI5;
            INST_ADDI_W, INST_SLTI, INST_SLTUI,
            INST_LD_B, INST_LD_H, INST_LD_W, INST_LD_BU, INST_LD_HU,
            INST_ST_B, INST_ST_H, INST_ST_W:                 imm_kind = IMM_SI12;
            INST_ANDI, INST_ORI, INST_XORI:                  imm_kind = IMM_UI12;
            INST_LU12I_W, INST_PCADDU12I:                    imm_kind = IMM_SI20;
            INST_BEQ, INST_BNE, INST_BLT, INST_BGE,
            INST_BLTU, INST_BGEU, INST_JIRL:                 imm_kind = IMM_OFFS16;
            INST_B, INST_BL:                                 imm_kind = IMM_OFFS26;
            default:                                         imm_kind = IMM_NONE;
        endcase
    end

    always_comb begin
        case (kind)
            INST_PCADDU12I, INST_BEQ, INST_BNE, INST_BLT, INST_BGE,
            INST_BLTU, INST_BGEU, INST_B, INST_BL:           src1 = SRC1_PC;
            INST_LU12I_W:                                    src1 = SRC1_ZERO;
            default:                                         src1 = SRC1_RJ;
        endcase
    end

    always_comb begin
        cmp = '0;
        case (kind)
            INST_SLT, INST_SLTI, INST_BEQ, INST_BNE, INST_BLT, INST_BGE:
                cmp.is_signed = 1'b1;
            default: ;
        endcase
        case (kind)
            INST_SLT, INST_SLTU, INST_SLTI, INST_SLTUI, INST_BLT, INST_BLTU:
                cmp.accept_lt = 1'b1;
            INST_BEQ:
                cmp.accept_eq = 1'b1;
            INST_BNE: begin
                cmp.accept_lt = 1'b1;
                cmp.accept_gt = 1'b1;
            end
            INST_BGE, INST_BGEU: begin
                cmp.accept_eq = 1'b1;
                cmp.accept_gt = 1'b1;
            end
            // unconditional, always taken
            INST_B, INST_BL, INST_JIRL: begin
                cmp.accept_lt = 1'b1;
                cmp.accept_eq = 1'b1;
                cmp.accept_gt = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (kind)
            INST_BEQ, INST_BNE, INST_BLT, INST_BGE, INST_BLTU, INST_BGEU,
            INST_B, INST_BL, INST_JIRL: is_branch = 1'b1;
            default:                    is_branch = 1'b0;
        endcase
    end

    always_comb begin
        case (kind)
            INST_LD_B, INST_ST_B: len = LEN_B;
            INST_LD_H, INST_ST_H: len = LEN_H;
            INST_LD_BU:           len = LEN_BU;
            INST_LD_HU:           len = LEN_HU;
            default:              len = LEN_W;
        endcase
        case (kind)
            INST_LD_B, INST_LD_H, INST_LD_W, INST_LD_BU, INST_LD_HU: rw = MEM_READ;
            INST_ST_B, INST_ST_H, INST_ST_W:                         rw = MEM_WRITE;
            default:                                                 rw = MEM_NONE;
        endcase
    end

    always_comb begin
        case (kind)
            INST_BL, INST_JIRL: wb_src = WB_PC4;
            default: begin
                if (rw == MEM_READ) begin
                    wb_src = WB_MEM;
                end else if (unit != EXU_NONE && unit != EXU_ALU) begin
                    wb_src = WB_EX;
                end else if (unit == EXU_ALU && !is_branch && rw == MEM_NONE) begin
                    wb_src = WB_EX;
                end else begin
                    wb_src = WB_NONE;
                end
            end
        endcase
    end

    always_comb begin
        ctrl.exec_unit = unit;
        ctrl.exec_op   = exec_op;
        ctrl.src1_sel  = src1;
        ctrl.src2_sel  = (imm_kind != IMM_NONE) ? SRC2_IMM : SRC2_RK;
        ctrl.cmp_cond  = cmp;
        ctrl.branch    = is_branch;
        ctrl.mem_len   = len;
        ctrl.mem_rw    = rw;
        ctrl.wb_valid  = (wb_src != WB_NONE);
        ctrl.wb_src    = wb_src;
        // bl links into r1
        ctrl.rd_index  = (kind == INST_BL) ? reg_idx_t'(1) : rd_field;
    end

endmodule

/* rtl/decode_pkg.sv */
package decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // one value per supported instruction
    typedef enum logic [5:0] {
        INST_INVALID = 6'd0,
        INST_ADD_W, INST_SUB_W, INST_ADDI_W, INST_LU12I_W, INST_PCADDU12I,
        INST_SLT, INST_SLTU, INST_SLTI, INST_SLTUI,
        INST_AND, INST_OR, INST_NOR, INST_XOR,
        INST_ANDI, INST_ORI, INST_XORI,
        INST_SLL_W, INST_SRL_W, INST_SRA_W,
        INST_SLLI_W, INST_SRLI_W, INST_SRAI_W,
        INST_MUL_W, INST_MULH_W, INST_MULH_WU,
        INST_DIV_W, INST_DIV_WU, INST_MOD_W, INST_MOD_WU,
        INST_BEQ, INST_BNE, INST_BLT, INST_BGE, INST_BLTU, INST_BGEU,
        INST_B, INST_BL, INST_JIRL,
        INST_LD_B, INST_LD_H, INST_LD_W, INST_LD_BU, INST_LD_HU,
        INST_ST_B, INST_ST_H, INST_ST_W
    } inst_kind_t;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_UI5,
        IMM_SI12,
        IMM_UI12,
        IMM_SI20,
        IMM_OFFS16,
        IMM_OFFS26
    } imm_kind_t;

    typedef enum logic [2:0] {
        EXU_NONE,
        EXU_ALU,
        EXU_MUL,
        EXU_DIV,
        EXU_CMP
    } exec_unit_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, NOR, XOR, SLL, SRL, SRA
    } alu_op_t;

    typedef enum logic [3:0] {
        MUL_LO, MUL_HI, MUL_HIU
    } mul_op_t;

    typedef enum logic [3:0] {
        DIV_Q, DIV_QU, DIV_R, DIV_RU
    } div_op_t;

    typedef enum logic [1:0] {
        SRC1_RJ, SRC1_PC, SRC1_ZERO
    } src1_sel_t;

    typedef enum logic {
        SRC2_RK, SRC2_IMM
    } src2_sel_t;

    // result is taken when the matching relation bit is set
    typedef struct packed {
        logic is_signed;
        logic accept_lt;
        logic accept_eq;
        logic accept_gt;
    } cmp_cond_t;

    // msb marks sign extension on loads
    typedef enum logic [2:0] {
        LEN_W  = 3'b100,
        LEN_B  = 3'b110,
        LEN_H  = 3'b101,
        LEN_BU = 3'b010,
        LEN_HU = 3'b001
    } mem_len_t;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_WRITE = 2'b01,
        MEM_READ  = 2'b10
    } mem_rw_t;

    typedef enum logic [1:0] {
        WB_NONE, WB_EX, WB_PC4, WB_MEM
    } wb_src_t;

    typedef struct packed {
        exec_unit_t exec_unit;
        logic [3:0] exec_op;
        src1_sel_t  src1_sel;
        src2_sel_t  src2_sel;
        cmp_cond_t  cmp_cond;
        logic       branch;
        mem_len_t   mem_len;
        mem_rw_t    mem_rw;
        logic       wb_valid;
        wb_src_t    wb_src;
        reg_idx_t   rd_index;
    } ctrl_t;

    typedef struct packed {
        logic     we;
        reg_idx_t index;
        word_t    data;
    } wb_req_t;

endpackage

/* rtl/decode_stage.sv */
module decode_stage
    import decode_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  word_t   inst,
    input  wb_req_t wb,
    output ctrl_t   ctrl,
    output word_t   imm,
    output word_t   rj_data,
    output word_t   rk_data
);

    inst_kind_t kind;
    imm_kind_t  imm_kind;

    inst_matcher u_inst_matcher (
        .inst (inst),
        .kind (kind)
    );

    ctrl_gen u_ctrl_gen (
        .kind     (kind),
        .rd_field (inst[4:0]),
        .ctrl     (ctrl),
        .imm_kind (imm_kind)
    );

    imm_gen u_imm_gen (
        .inst     (inst),
        .imm_kind (imm_kind),
        .imm      (imm)
    );

    // rj in bits 9:5, rk in bits 14:10
    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rj_index (inst[9:5]),
        .rk_index (inst[14:10]),
        .wb       (wb),
        .rj_data  (rj_data),
        .rk_data  (rk_data)
    );

endmodule

/* rtl/imm_gen.sv */
module imm_gen
    import decode_pkg::*;
(
    input  word_t     inst,
    input  imm_kind_t imm_kind,
    output word_t     imm
);

    always_comb begin
        case (imm_kind)
            IMM_UI5: begin
                imm = {27'b0, inst[14:10]};
            end
            IMM_SI12: begin
                imm = {{20{inst[21]}}, inst[21:10]};
            end
            IMM_UI12: begin
                imm = {20'b0, inst[21:10]};
            end
            IMM_SI20: begin
                imm = {inst[24:5], 12'b0};
            end
            // branch offsets are word aligned
            IMM_OFFS16: begin
                imm = {{14{inst[25]}}, inst[25:10], 2'b0};
            end
            IMM_OFFS26: begin
                // high part sits in the low bits of the word
                imm = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* rtl/inst_matcher.sv */
module inst_matcher
    import decode_pkg::*;
(
    input  word_t      inst,
    output inst_kind_t kind
);

    logic [63:0] op_31_26_d;
    logic [15:0] op_25_22_d;
    logic [3:0]  op_21_20_d;
    logic [31:0] op_19_15_d;

    // one-hot field decoders
    for (genvar i = 0; i < 64; i++) begin : g_dec_31_26
        assign op_31_26_d[i] = (inst[31:26] == 6'(i));
    end

    for (genvar i = 0; i < 16; i++) begin : g_dec_25_22
        assign op_25_22_d[i] = (inst[25:22] == 4'(i));
    end

    for (genvar i = 0; i < 4; i++) begin : g_dec_21_20
        assign op_21_20_d[i] = (inst[21:20] == 2'(i));
    end

    for (genvar i = 0; i < 32; i++) begin : g_dec_19_15
        assign op_19_15_d[i] = (inst[19:15] == 5'(i));
    end

    logic op_00;
    logic op_mem;
    logic grp_3r;
    logic grp_div;
    logic grp_shift;
    logic [63:0] hit;

    assign op_00     = op_31_26_d[6'h00];
    assign op_mem    = op_31_26_d[6'h0a];
    assign grp_3r    = op_00 & op_25_22_d[4'h0] & op_21_20_d[2'h1];
    assign grp_div   = op_00 & op_25_22_d[4'h0] & op_21_20_d[2'h2];
    assign grp_shift = op_00 & op_25_22_d[4'h1] & op_21_20_d[2'h0];

    always_comb begin
        hit = '0;
        // three-register forms
        hit[INST_ADD_W]     = grp_3r & op_19_15_d[5'h00];
        hit[INST_SUB_W]     = grp_3r & op_19_15_d[5'h02];
        hit[INST_SLT]       = grp_3r & op_19_15_d[5'h04];
        hit[INST_SLTU]      = grp_3r & op_19_15_d[5'h05];
        hit[INST_NOR]       = grp_3r & op_19_15_d[5'h08];
        hit[INST_AND]       = grp_3r & op_19_15_d[5'h09];
        hit[INST_OR]        = grp_3r & op_19_15_d[5'h0a];
        hit[INST_XOR]       = grp_3r & op_19_15_d[5'h0b];
        hit[INST_SLL_W]     = grp_3r & op_19_15_d[5'h0e];
        hit[INST_SRL_W]     = grp_3r & op_19_15_d[5'h0f];
        hit[INST_SRA_W]     = grp_3r & op_19_15_d[5'h10];
        hit[INST_MUL_W]     = grp_3r & op_19_15_d[5'h18];
        hit[INST_MULH_W]    = grp_3r & op_19_15_d[5'h19];
        hit[INST_MULH_WU]   = grp_3r & op_19_15_d[5'h1a];
        hit[INST_DIV_W]     = grp_div & op_19_15_d[5'h00];
        hit[INST_MOD_W]     = grp_div & op_19_15_d[5'h01];
        hit[INST_DIV_WU]    = grp_div & op_19_15_d[5'h02];
        hit[INST_MOD_WU]    = grp_div & op_19_15_d[5'h03];
        hit[INST_SLLI_W]    = grp_shift & op_19_15_d[5'h01];
        hit[INST_SRLI_W]    = grp_shift & op_19_15_d[5'h09];
        hit[INST_SRAI_W]    = grp_shift & op_19_15_d[5'h11];
        // 12-bit immediate forms
        hit[INST_SLTI]      = op_00 & op_25_22_d[4'h8];
        hit[INST_SLTUI]     = op_00 & op_25_22_d[4'h9];
        hit[INST_ADDI_W]    = op_00 & op_25_22_d[4'ha];
        hit[INST_ANDI]      = op_00 & op_25_22_d[4'hd];
        hit[INST_ORI]       = op_00 & op_25_22_d[4'he];
        hit[INST_XORI]      = op_00 & op_25_22_d[4'hf];
        hit[INST_LD_B]      = op_mem & op_25_22_d[4'h0];
        hit[INST_LD_H]      = op_mem & op_25_22_d[4'h1];
        hit[INST_LD_W]      = op_mem & op_25_22_d[4'h2];
        hit[INST_ST_B]      = op_mem & op_25_22_d[4'h4];
        hit[INST_ST_H]      = op_mem & op_25_22_d[4'h5];
        hit[INST_ST_W]      = op_mem & op_25_22_d[4'h6];
        hit[INST_LD_BU]     = op_mem & op_25_22_d[4'h8];
        hit[INST_LD_HU]     = op_mem & op_25_22_d[4'h9];
        // branches and jumps use the top field only
        hit[INST_JIRL]      = op_31_26_d[6'h13];
        hit[INST_B]         = op_31_26_d[6'h14];
        hit[INST_BL]        = op_31_26_d[6'h15];
        hit[INST_BEQ]       = op_31_26_d[6'h16];
        hit[INST_BNE]       = op_31_26_d[6'h17];
        hit[INST_BLT]       = op_31_26_d[6'h18];
        hit[INST_BGE]       = op_31_26_d[6'h19];
        hit[INST_BLTU]      = op_31_26_d[6'h1a];
        hit[INST_BGEU]      = op_31_26_d[6'h1b];
        hit[INST_LU12I_W]   = op_31_26_d[6'h05] & ~inst[25];
        hit[INST_PCADDU12I] = op_31_26_d[6'h07] & ~inst[25];
    end

    // lowest kind wins, nothing matched stays invalid
    always_comb begin
        kind = INST_INVALID;
        for (int i = 63; i > 0; i--) begin
            if (hit[i]) begin
                kind = inst_kind_t'(i);
            end
        end
    end

endmodule

/* rtl/reg_file.sv */
module reg_file
    import decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rj_index,
    input  reg_idx_t rk_index,
    input  wb_req_t  wb,
    output word_t    rj_data,
    output word_t    rk_data
);

    localparam int depth = 2 ** reg_addr_w;

    word_t regs [depth];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.index != '0) begin
            regs[wb.index] <= wb.data;
        end
    end

    // r0 is hardwired to zero
    assign rj_data = (rj_index == '0) ? '0 : regs[rj_index];
    assign rk_data = (rk_index == '0) ? '0 : regs[rk_index];

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/100ps --top-module decode_stage_tb -f all.f -o decode_sim \
    && ./obj_dir/decode_sim | tee /dev/stderr | grep -q "Everything OK" \
    && echo "decode stage simulation passed" \
    || { echo "decode stage simulation failed"; exit 1; }

/* tb/decode_vectors.svh */
// columns: opcode bits, mask of the fixed opcode bits, exec unit, exec op, src1 select,
// compare condition {signed, lt, eq, gt}, branch, mem length, mem direction, wb source,
// imm kind and, for bl only, the fixed link register

localparam word_t op6  = 32'hfc000000;
localparam word_t op7  = 32'hfe000000;
localparam word_t op10 = 32'hffc00000;
localparam word_t op17 = 32'hffff8000;

typedef struct packed {
    word_t      base;
    word_t      mask;
    exec_unit_t unit;
    logic [3:0] op;
    src1_sel_t  src1;
    cmp_cond_t  cmp;
    int         br;
    mem_len_t   len;
    mem_rw_t    rw;
    wb_src_t    wbs;
    imm_kind_t  ik;
    int         rd;
} vec_t;

vec_t vectors[$];

function automatic void load_vectors();
    add_row('h00100000, op17, EXU_ALU, ADD, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h00110000, op17, EXU_ALU, SUB, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h02800000, op10, EXU_ALU, ADD, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_SI12);
    add_row('h14000000, op7, EXU_ALU, ADD, SRC1_ZERO, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_SI20);
    add_row('h1c000000, op7, EXU_ALU, ADD, SRC1_PC, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_SI20);
    add_row('h00120000, op17, EXU_CMP, 4'h0, SRC1_RJ, 'hc, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h00128000, op17, EXU_CMP, 4'h0, SRC1_RJ, 'h4, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h02000000, op10, EXU_CMP, 4'h0, SRC1_RJ, 'hc, 0, LEN_W, MEM_NONE, WB_EX, IMM_SI12);
    add_row('h02400000, op10, EXU_CMP, 4'h0, SRC1_RJ, 'h4, 0, LEN_W, MEM_NONE, WB_EX, IMM_SI12);
    add_row('h00148000, op17, EXU_ALU, AND, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h00150000, op17, EXU_ALU, OR, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h00140000, op17, EXU_ALU, NOR, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h00158000, op17, EXU_ALU, XOR, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h03400000, op10, EXU_ALU, AND, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_UI12);
    add_row('h03800000, op10, EXU_ALU, OR, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_UI12);
    add_row('h03c00000, op10, EXU_ALU, XOR, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_UI12);
    add_row('h00170000, op17, EXU_ALU, SLL, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h00178000, op17, EXU_ALU, SRL, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h00180000, op17, EXU_ALU, SRA, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h00408000, op17, EXU_ALU, SLL, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_UI5);
    add_row('h00448000, op17, EXU_ALU, SRL, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_UI5);
    add_row('h00488000, op17, EXU_ALU, SRA, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_UI5);
    add_row('h001c0000, op17, EXU_MUL, MUL_LO, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h001c8000, op17, EXU_MUL, MUL_HI, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h001d0000, op17, EXU_MUL, MUL_HIU, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h00200000, op17, EXU_DIV, DIV_Q, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h00210000, op17, EXU_DIV, DIV_QU, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h00208000, op17, EXU_DIV, DIV_R, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h00218000, op17, EXU_DIV, DIV_RU, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_EX, IMM_NONE);
    add_row('h58000000, op6, EXU_ALU, ADD, SRC1_PC, 'ha, 1, LEN_W, MEM_NONE, WB_NONE, IMM_OFFS16);
    add_row('h5c000000, op6, EXU_ALU, ADD, SRC1_PC, 'hd, 1, LEN_W, MEM_NONE, WB_NONE, IMM_OFFS16);
    add_row('h60000000, op6, EXU_ALU, ADD, SRC1_PC, 'hc, 1, LEN_W, MEM_NONE, WB_NONE, IMM_OFFS16);
    add_row('h64000000, op6, EXU_ALU, ADD, SRC1_PC, 'hb, 1, LEN_W, MEM_NONE, WB_NONE, IMM_OFFS16);
    add_row('h68000000, op6, EXU_ALU, ADD, SRC1_PC, 'h4, 1, LEN_W, MEM_NONE, WB_NONE, IMM_OFFS16);
    add_row('h6c000000, op6, EXU_ALU, ADD, SRC1_PC, 'h3, 1, LEN_W, MEM_NONE, WB_NONE, IMM_OFFS16);
    add_row('h50000000, op6, EXU_ALU, ADD, SRC1_PC, 'h7, 1, LEN_W, MEM_NONE, WB_NONE, IMM_OFFS26);
    add_row('h54000000, op6, EXU_ALU, ADD, SRC1_PC, 'h7, 1, LEN_W, MEM_NONE, WB_PC4, IMM_OFFS26, 1);
    add_row('h4c000000, op6, EXU_ALU, ADD, SRC1_RJ, 'h7, 1, LEN_W, MEM_NONE, WB_PC4, IMM_OFFS16);
    add_row('h28000000, op10, EXU_ALU, ADD, SRC1_RJ, 'h0, 0, LEN_B, MEM_READ, WB_MEM, IMM_SI12);
    add_row('h28400000, op10, EXU_ALU, ADD, SRC1_RJ, 'h0, 0, LEN_H, MEM_READ, WB_MEM, IMM_SI12);
    add_row('h28800000, op10, EXU_ALU, ADD, SRC1_RJ, 'h0, 0, LEN_W, MEM_READ, WB_MEM, IMM_SI12);
    add_row('h2a000000, op10, EXU_ALU, ADD, SRC1_RJ, 'h0, 0, LEN_BU, MEM_READ, WB_MEM, IMM_SI12);
    add_row('h2a400000, op10, EXU_ALU, ADD, SRC1_RJ, 'h0, 0, LEN_HU, MEM_READ, WB_MEM, IMM_SI12);
    add_row('h29000000, op10, EXU_ALU, ADD, SRC1_RJ, 'h0, 0, LEN_B, MEM_WRITE, WB_NONE, IMM_SI12);
    add_row('h29400000, op10, EXU_ALU, ADD, SRC1_RJ, 'h0, 0, LEN_H, MEM_WRITE, WB_NONE, IMM_SI12);
    add_row('h29800000, op10, EXU_ALU, ADD, SRC1_RJ, 'h0, 0, LEN_W, MEM_WRITE, WB_NONE, IMM_SI12);
    // csrrd, syscall, dbar, ll.w and lu32i.d are outside the kept set
    add_row('h04000000, 'hff0003e0, EXU_NONE, 4'h0, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_NONE,
            IMM_NONE);
    add_row('h002b0000, op17, EXU_NONE, 4'h0, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_NONE, IMM_NONE);
    add_row('h38720000, op17, EXU_NONE, 4'h0, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_NONE, IMM_NONE);
    add_row('h20000000, 'hff000000, EXU_NONE, 4'h0, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_NONE,
            IMM_NONE);
    add_row('h16000000, op7, EXU_NONE, 4'h0, SRC1_RJ, 'h0, 0, LEN_W, MEM_NONE, WB_NONE, IMM_NONE);
endfunction

/* tb/decode_stage_tb.sv */
module decode_stage_tb
    import decode_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // cycles spent outside the vector table
    localparam int reg_cycles = 228;

    logic    clk;
    logic    rst_n;
    word_t   inst;
    wb_req_t wb;
    ctrl_t   ctrl;
    word_t   imm;
    word_t   rj_data;
    word_t   rk_data;

    int      seed;
    word_t   exp_regs [32];

    `include "decode_vectors.svh"

    decode_stage u_decode_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst    (inst),
        .wb      (wb),
        .ctrl    (ctrl),
        .imm     (imm),
        .rj_data (rj_data),
        .rk_data (rk_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic void add_row(input word_t base, input word_t mask, input exec_unit_t unit,
                                    input logic [3:0] op, input src1_sel_t src1, input int cmp,
                                    input int br, input mem_len_t len, input mem_rw_t rw,
                                    input wb_src_t wbs, input imm_kind_t ik, input int rd = 0);
        vec_t v;
        v.base = base;
        v.mask = mask;
        v.unit = unit;
        v.op   = op;
        v.src1 = src1;
        v.cmp  = cmp[3:0];
        v.br   = br;
        v.len  = len;
        v.rw   = rw;
        v.wbs  = wbs;
        v.ik   = ik;
        v.rd   = rd;
        vectors.push_back(v);
    endfunction

    // immediate formats of the integer subset
    function automatic word_t expected_imm(input word_t w, input imm_kind_t k);
        logic [25:0] offs26;
        offs26 = {w[9:0], w[25:10]};
        case (k)
            IMM_UI5:    return word_t'(w[14:10]);
            IMM_SI12:   return word_t'($signed(w[21:10]));
            IMM_UI12:   return word_t'(w[21:10]);
            IMM_SI20:   return word_t'(w[24:5]) << 12;
            IMM_OFFS16: return word_t'($signed(w[25:10])) << 2;
            IMM_OFFS26: return word_t'($signed(offs26)) << 2;
            default:    return '0;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("Something failed");
        $fatal(1, "%s", why);
    endtask

    function automatic int field_diff(input string name, input logic [31:0] exp,
                                      input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %0h got %0h", $time, name, exp, act);
            return 1;
        end
        return 0;
    endfunction

    task automatic check_ctrl(input ctrl_t exp, input ctrl_t act);
        int bad;
        bad = 0;
        bad += field_diff("ctrl.exec_unit", 32'(exp.exec_unit), 32'(act.exec_unit));
        bad += field_diff("ctrl.exec_op", 32'(exp.exec_op), 32'(act.exec_op));
        bad += field_diff("ctrl.src1_sel", 32'(exp.src1_sel), 32'(act.src1_sel));
        bad += field_diff("ctrl.src2_sel", 32'(exp.src2_sel), 32'(act.src2_sel));
        bad += field_diff("ctrl.cmp_cond", 32'(exp.cmp_cond), 32'(act.cmp_cond));
        bad += field_diff("ctrl.branch", 32'(exp.branch), 32'(act.branch));
        bad += field_diff("ctrl.mem_len", 32'(exp.mem_len), 32'(act.mem_len));
        bad += field_diff("ctrl.mem_rw", 32'(exp.mem_rw), 32'(act.mem_rw));
        bad += field_diff("ctrl.wb_valid", 32'(exp.wb_valid), 32'(act.wb_valid));
        bad += field_diff("ctrl.wb_src", 32'(exp.wb_src), 32'(act.wb_src));
        bad += field_diff("ctrl.rd_index", 32'(exp.rd_index), 32'(act.rd_index));
        if (bad != 0) begin
            abort_run("control bundle mismatch");
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
            abort_run("data word mismatch");
        end
    endtask

    initial begin : watchdog
        #1;
        #((vectors.size() + reg_cycles) * 8 + 200);
        $display("timeout: the test sequence did not finish in time");
        abort_run("watchdog expired");
    end

    initial begin
        word_t rnd;
        ctrl_t exp;
        vec_t  v;
        $timeformat(-9, 1, " ns", 0);
        seed   = 52;
        inst   = '0;
        wb     = '0;
        rst_n  = 1'b0;
        load_vectors();
        foreach (exp_regs[i]) begin
            exp_regs[i] = '0;
        end

        // inst 0 is no kept encoding, so the bundle is inactive under reset
        @(negedge clk);
        #2;
        exp = '0;
        exp.mem_len = LEN_W;
        check_ctrl(exp, ctrl);
        check_word("imm", '0, imm);
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            inst = {17'b0, reg_idx_t'(31 - i), reg_idx_t'(i), 5'b0};
            #2;
            check_word("rj_data", '0, rj_data);
            check_word("rk_data", '0, rk_data);
        end

        // second pass sees the first pass values as old data
        for (int pass = 0; pass < 2; pass++) begin
            for (int r = 1; r < 32; r++) begin
                rnd = $random(seed);
                @(negedge clk);
                wb = '{we: 1'b1, index: reg_idx_t'(r), data: rnd};
                inst = {17'b0, reg_idx_t'(r), reg_idx_t'(r), 5'b0};
                #2;
                check_word("rj_data", exp_regs[r], rj_data);
                check_word("rk_data", exp_regs[r], rk_data);
                exp_regs[r] = rnd;
                @(negedge clk);
                wb.we = 1'b0;
                #2;
                check_word("rj_data", exp_regs[r], rj_data);
                check_word("rk_data", exp_regs[r], rk_data);
            end
        end

        rnd = $random(seed);
        @(negedge clk);
        wb = '{we: 1'b1, index: '0, data: rnd};
        inst = '0;
        @(negedge clk);
        wb.we = 1'b0;
        #2;
        check_word("rj_data", '0, rj_data);
        check_word("rk_data", '0, rk_data);

        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            inst = {17'b0, reg_idx_t'(31 - i), reg_idx_t'(i), 5'b0};
            #2;
            check_word("rj_data", exp_regs[i], rj_data);
            check_word("rk_data", exp_regs[31 - i], rk_data);
        end

        // registers hold written data now, a second reset must clear them
        @(negedge clk);
        rst_n = 1'b0;
        @(negedge clk);
        rst_n = 1'b1;
        foreach (exp_regs[i]) begin
            exp_regs[i] = '0;
        end

        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            inst = {17'b0, reg_idx_t'(31 - i), reg_idx_t'(i), 5'b0};
            #2;
            check_word("rj_data", '0, rj_data);
            check_word("rk_data", '0, rk_data);
        end

        foreach (vectors[n]) begin
            v = vectors[n];
            rnd = $random(seed);
            @(negedge clk);
            inst = (v.base & v.mask) | (rnd & ~v.mask);
            #2;
            exp = '0;
            exp.exec_unit = v.unit;
            exp.exec_op   = v.op;
            exp.src1_sel  = v.src1;
            exp.src2_sel  = (v.ik != IMM_NONE) ? SRC2_IMM : SRC2_RK;
            exp.cmp_cond  = v.cmp;
            exp.branch    = v.br[0];
            exp.mem_len   = v.len;
            exp.mem_rw    = v.rw;
            exp.wb_valid  = (v.wbs != WB_NONE);
            exp.wb_src    = v.wbs;
            exp.rd_index  = (v.rd != 0) ? v.rd[4:0] : inst[4:0];
            check_ctrl(exp, ctrl);
            check_word("imm", expected_imm(inst, v.ik), imm);
        end

        $display("Everything OK");
        $finish;
    end

endmodule
